// ==== list.f ====
source/movegen_pkg.sv
source/board_decode.sv
source/leaper_attacks.sv
source/slider_attacks.sv
source/piece_scanner.sv
source/move_emitter.sv
source/movegen_top.sv
verif/movegen_assert.sv
verif/movegen_checker.sv
verif/movegen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= movegen_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/movegen_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module movegen_tb;
    import movegen_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES = 60;
    localparam int NUM_TESTS = 25;
    localparam int FIRST_RANDOM = 5;
    localparam int MAX_PAWNS = 6;
    localparam int MAX_KNIGHTS = 3;
    localparam int MAX_BISHOPS = 3;
    localparam int MAX_ROOKS = 3;
    localparam int MAX_QUEENS = 2;
    localparam int MAX_MOVES = 8 + 8 * MAX_KNIGHTS + 13 * MAX_BISHOPS + 14 * MAX_ROOKS
                             + 27 * MAX_QUEENS;
    localparam int SETUP_CYCLES = 2 * (2 + MAX_KNIGHTS + MAX_BISHOPS + MAX_ROOKS
                                + 2 * MAX_QUEENS) + 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 * MAX_MOVES + SETUP_CYCLES)
                                  + RESET_CYCLES + HOLD_CYCLES;

    logic   clk_in;
    logic   rst_in;
    board_t board_in;
    logic   board_valid;
    logic   captures_only;
    logic   credit_return;
    logic   board_ready;
    move_t  move_out;
    logic   move_valid;
    logic   list_done;
    logic   hold_credits;
    int     test_id;
    int     tests_run;
    int     error_count;
    int     cycles = 0;

    movegen_top DUT (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .board_in      (board_in),
        .board_valid   (board_valid),
        .captures_only (captures_only),
        .credit_return (credit_return),
        .board_ready   (board_ready),
        .move_out      (move_out),
        .move_valid    (move_valid),
        .list_done     (list_done)
    );

    movegen_checker u_checker (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .board_in      (board_in),
        .board_valid   (board_valid),
        .captures_only (captures_only),
        .board_ready   (board_ready),
        .credit_return (credit_return),
        .move_out      (move_out),
        .move_valid    (move_valid),
        .list_done     (list_done),
        .test_id       (test_id),
        .tests_run     (tests_run),
        .error_count   (error_count)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // each move frees its credit after 0 to 5 cycles unless credits are held
    initial begin
        int unsigned release_at[$];
        int unsigned tick;

        tick = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge clk_in);
            tick++;
            if (move_valid) begin
                release_at.push_back(tick + $urandom_range(5, 0));
            end
            #1;
            if (!hold_credits && release_at.size() > 0 && release_at[0] <= tick) begin
                credit_return = 1'b1;
                void'(release_at.pop_front());
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    function automatic int at(input int fil, input int rnk);
        return (rnk - 1) * 8 + fil;
    endfunction

    function automatic int piece_limit(input int kind);
        case (kind)
            0: return MAX_PAWNS;
            1: return MAX_KNIGHTS;
            2: return MAX_BISHOPS;
            3: return MAX_ROOKS;
            default: return MAX_QUEENS;
        endcase
    endfunction

    task automatic place(inout board_t b, input int kind, input int sq, input bit white);
        b.pieces[kind][sq] = 1'b1;
        b.white_men[sq] = white;
    endtask

    task automatic set_kings(inout board_t b, input int wk, input int bk);
        b.kings[0] = square_t'(6'(wk));
        b.kings[1] = square_t'(6'(bk));
        b.white_men[wk] = 1'b1;
    endtask

    task automatic pick_square(inout logic [63:0] taken, output int sq);
        sq = $urandom_range(63, 0);
        while (taken[sq]) begin
            sq = $urandom_range(63, 0);
        end
        taken[sq] = 1'b1;
    endtask

    task automatic random_board(output board_t b, input bit dense);
        logic [63:0] taken;
        int          wk;
        int          bk;
        int          sq;
        int          count;

        b = '0;
        taken = '0;
        pick_square(taken, wk);
        pick_square(taken, bk);
        set_kings(b, wk, bk);
        for (int k = 0; k < 5; k++) begin
            count = dense ? piece_limit(k) : $urandom_range(piece_limit(k), 0);
            for (int n = 0; n < count; n++) begin
                pick_square(taken, sq);
                place(b, k, sq, 1'($urandom_range(1, 0)));
            end
        end
        b.black_to_move = 1'($urandom_range(1, 0));
    endtask

    // holds board_valid until the board is accepted
    task automatic send_board(input board_t b, input logic cap, input int id);
        board_in = b;
        captures_only = cap;
        test_id = id;
        board_valid = 1'b1;
        @(posedge clk_in);
        while (!board_ready) begin
            @(posedge clk_in);
        end
        #1;
        board_valid = 1'b0;
    endtask

    initial begin
        board_t b;

        void'($urandom(32'h4b9b5d65));
        rst_in = 1'b1;
        board_in = '0;
        board_valid = 1'b0;
        captures_only = 1'b0;
        hold_credits = 1'b0;
        test_id = 0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        b = '0;
        set_kings(b, at(4, 1), at(4, 8));
        send_board(b, 1'b0, 0);

        // leapers in corners and on edges
        b = '0;
        set_kings(b, at(7, 1), at(3, 8));
        place(b, KNIGHT, at(0, 1), 1'b1);
        place(b, KNIGHT, at(7, 8), 1'b1);
        place(b, KNIGHT, at(0, 5), 1'b1);
        place(b, KNIGHT, at(7, 4), 1'b1);
        place(b, KNIGHT, at(1, 3), 1'b0);
        send_board(b, 1'b0, 1);

        b = '0;
        set_kings(b, at(1, 1), at(4, 8));
        place(b, QUEEN, at(3, 4), 1'b1);
        place(b, ROOK, at(0, 1), 1'b1);
        place(b, BISHOP, at(2, 1), 1'b1);
        place(b, PAWN, at(3, 6), 1'b1);
        place(b, KNIGHT, at(6, 7), 1'b0);
        place(b, BISHOP, at(1, 6), 1'b0);
        send_board(b, 1'b0, 2);
        send_board(b, 1'b1, 3);

        random_board(b, 1'b1);
        send_board(b, 1'b0, 4);
        hold_credits = 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk_in);
        #1;
        hold_credits = 1'b0;

        for (int t = FIRST_RANDOM; t < NUM_TESTS; t++) begin
            random_board(b, 1'b0);
            send_board(b, 1'($urandom_range(1, 0)), t);
        end

        wait (tests_run == NUM_TESTS);
        repeat (4) @(posedge clk_in);
        $display("tests run %0d of %0d, errors %0d", tests_run, NUM_TESTS, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/movegen_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module movegen_checker (
    input  logic                clk_in,
    input  logic                rst_in,
    input  movegen_pkg::board_t board_in,
    input  logic                board_valid,
    input  logic                captures_only,
    input  logic                board_ready,
    input  logic                credit_return,
    input  movegen_pkg::move_t  move_out,
    input  logic                move_valid,
    input  logic                list_done,
    input  int                  test_id,
    output int                  tests_run,
    output int                  error_count
);
    import movegen_pkg::*;

    move_t expected[$];
    int    cur_test;
    int    next_idx;
    int    test_errors;
    int    outstanding;
    logic  in_flight;

    function automatic string test_name(input int id);
        case (id)
            0: return "lone_king";
            1: return "edge_leapers";
            2: return "slider_blockers";
            3: return "slider_captures";
            4: return "credit_hold";
            default: return $sformatf("random_%0d", id);
        endcase
    endfunction

    function automatic string move_name(input move_t m);
        return $sformatf("%c%0d%c%0d", 8'd97 + m.src.fil, m.src.rnk + 1,
                         8'd97 + m.dst.fil, m.dst.rnk + 1);
    endfunction

    // king or knight offsets, dropping anything that leaves the board
    function automatic logic [63:0] leaper_set(input int src, input bit knight);
        logic [63:0] set;
        int          r;
        int          f;
        int          ar;
        int          af;

        set = '0;
        for (int dr = -2; dr <= 2; dr++) begin
            for (int df = -2; df <= 2; df++) begin
                ar = dr < 0 ? -dr : dr;
                af = df < 0 ? -df : df;
                r = src / 8 + dr;
                f = src % 8 + df;
                if (r >= 0 && r < 8 && f >= 0 && f < 8) begin
                    if (knight ? (ar * af == 2) : (ar <= 1 && af <= 1 && ar + af > 0)) begin
                        set[r*8 + f] = 1'b1;
                    end
                end
            end
        end
        return set;
    endfunction

    // walk each direction until the edge or the first occupied square
    function automatic logic [63:0] ray_set(input int src, input logic [63:0] occ,
                                            input bit diag);
        logic [63:0] set;
        int          dr;
        int          df;
        int          r;
        int          f;
        bit          blocked;

        set = '0;
        for (int dir = 0; dir < 4; dir++) begin
            if (diag) begin
                dr = (dir & 1) ? 1 : -1;
                df = (dir & 2) ? 1 : -1;
            end else begin
                dr = dir == 0 ? 1 : (dir == 1 ? -1 : 0);
                df = dir == 2 ? 1 : (dir == 3 ? -1 : 0);
            end
            r = src / 8 + dr;
            f = src % 8 + df;
            blocked = 1'b0;
            while (!blocked && r >= 0 && r < 8 && f >= 0 && f < 8) begin
                set[r*8 + f] = 1'b1;
                blocked = occ[r*8 + f];
                r += dr;
                f += df;
            end
        end
        return set;
    endfunction

    task automatic push_moves(input int src, input logic [63:0] reach,
                              input logic [63:0] allowed);
        for (int d = 0; d < 64; d++) begin
            if (reach[d] && allowed[d]) begin
                expected.push_back({6'(src), 6'(d)});
            end
        end
    endtask

    task automatic build_expected(input board_t b, input logic cap);
        logic [63:0] occ;
        logic [63:0] own;
        logic [63:0] allowed;
        int          ks;

        expected.delete();
        occ = '0;
        for (int k = 0; k < 5; k++) begin
            occ = occ | b.pieces[k];
        end
        occ[b.kings[0]] = 1'b1;
        occ[b.kings[1]] = 1'b1;
        own = occ & (b.black_to_move ? ~b.white_men : b.white_men);
        allowed = cap ? (occ & ~own) : ~own;
        ks = b.black_to_move ? int'(b.kings[1]) : int'(b.kings[0]);

        push_moves(ks, leaper_set(ks, 1'b0), allowed);
        for (int s = 0; s < 64; s++) begin
            if (own[s] && b.pieces[KNIGHT][s]) begin
                push_moves(s, leaper_set(s, 1'b1), allowed);
            end
        end
        for (int s = 0; s < 64; s++) begin
            if (own[s] && (b.pieces[BISHOP][s] || b.pieces[QUEEN][s])) begin
                push_moves(s, ray_set(s, occ, 1'b1), allowed);
            end
        end
        for (int s = 0; s < 64; s++) begin
            if (own[s] && (b.pieces[ROOK][s] || b.pieces[QUEEN][s])) begin
                push_moves(s, ray_set(s, occ, 1'b0), allowed);
            end
        end
    endtask

    task automatic check_move(input move_t m);
        if (!in_flight) begin
            $display("move %s arrived with no board in flight", move_name(m));
            error_count++;
        end else if (next_idx >= expected.size()) begin
            $display("extra move %s in %s after the expected list ended",
                     move_name(m), test_name(cur_test));
            test_errors++;
            error_count++;
        end else begin
            if (m !== expected[next_idx]) begin
                $display("Mismatch in %s at move %0d: expected %s, actual %s",
                         test_name(cur_test), next_idx, move_name(expected[next_idx]),
                         move_name(m));
                test_errors++;
                error_count++;
            end
            next_idx++;
        end
        if (outstanding >= MOVE_CREDITS) begin
            $display("move %s arrived while %0d moves were still holding credits",
                     move_name(m), outstanding);
            error_count++;
        end
    endtask

    task automatic finish_test();
        if (!in_flight) begin
            $display("list_done arrived with no board in flight");
            error_count++;
        end else begin
            if (next_idx < expected.size()) begin
                $display("%0d moves missing from %s when list_done arrived",
                         expected.size() - next_idx, test_name(cur_test));
                test_errors++;
                error_count++;
            end
            $display("test %-16s %3d moves  %0d errors", test_name(cur_test), next_idx,
                     test_errors);
            tests_run++;
            in_flight = 1'b0;
        end
    endtask

    always @(posedge clk_in) begin
        if (rst_in) begin
            tests_run = 0;
            error_count = 0;
            outstanding = 0;
            in_flight = 1'b0;
            next_idx = 0;
            test_errors = 0;
            cur_test = 0;
        end else begin
            if (move_valid) begin
                check_move(move_out);
            end
            outstanding = outstanding + int'(move_valid) - int'(credit_return);
            if (list_done) begin
                finish_test();
            end
            if (board_valid && board_ready) begin
                build_expected(board_in, captures_only);
                cur_test = test_id;
                next_idx = 0;
                test_errors = 0;
                in_flight = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/movegen_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module movegen_assert (
    input logic clk_in,
    input logic rst_in,
    input logic board_valid,
    input logic board_ready,
    input logic credit_return,
    input logic move_valid,
    input logic list_done
);
    import movegen_pkg::*;

    int outstanding;

    // moves seen at the output that the consumer has not yet freed
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(move_valid) - int'(credit_return);
        end
    end

    credit_limit: assert property (@(posedge clk_in) disable iff (rst_in)
        move_valid |-> outstanding < MOVE_CREDITS)
        else $error("move issued while every credit was in use");

    // ready falls right after an accept and only comes back after list_done
    busy_after_accept: assert property (@(posedge clk_in) disable iff (rst_in)
        (board_valid && board_ready) |=> !board_ready)
        else $error("board_ready still high the cycle after an accept");

    ready_after_done: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(board_ready) |-> $past(list_done))
        else $error("board_ready rose without a list_done the cycle before");

    no_move_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        move_valid |-> !board_ready)
        else $error("move issued while board_ready was high");

endmodule

bind movegen_top movegen_assert u_assert (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .board_valid   (board_valid),
    .board_ready   (board_ready),
    .credit_return (credit_return),
    .move_valid    (move_valid),
    .list_done     (list_done)
);

`default_nettype wire

// ==== source/movegen_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module movegen_top (
    input  logic                clk_in,
    input  logic                rst_in,
    input  movegen_pkg::board_t board_in,
    input  logic                board_valid,
    input  logic                captures_only,
    input  logic                credit_return,
    output logic                board_ready,
    output movegen_pkg::move_t  move_out,
    output logic                move_valid,
    output logic                list_done
);
    import movegen_pkg::*;

    decoded_t decoded;
    logic     start;
    move_t    offer;
    logic     offer_valid;
    logic     take;
    logic     scan_end;

    board_decode u_decode (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .board_in      (board_in),
        .board_valid   (board_valid),
        .captures_only (captures_only),
        .list_done     (list_done),
        .board_ready   (board_ready),
        .decoded       (decoded),
        .start         (start)
    );

    piece_scanner u_scanner (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .decoded     (decoded),
        .start       (start),
        .take        (take),
        .offer       (offer),
        .offer_valid (offer_valid),
        .scan_end    (scan_end)
    );

    move_emitter u_emitter (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .offer         (offer),
        .offer_valid   (offer_valid),
        .scan_end      (scan_end),
        .credit_return (credit_return),
        .take          (take),
        .move_out      (move_out),
        .move_valid    (move_valid),
        .list_done     (list_done)
    );

endmodule

`default_nettype wire

// ==== source/move_emitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module move_emitter (
    input  logic               clk_in,
    input  logic               rst_in,
    input  movegen_pkg::move_t offer,
    input  logic               offer_valid,
    input  logic               scan_end,
    input  logic               credit_return,
    output logic               take,
    output movegen_pkg::move_t move_out,
    output logic               move_valid,
    output logic               list_done
);
    import movegen_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                credits_full;

    // one credit per move in flight toward the consumer
    assign take = offer_valid && (credits != '0);
    assign credits_full = credits == CREDIT_W'(MOVE_CREDITS);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            credits <= CREDIT_W'(MOVE_CREDITS);
            move_valid <= 1'b0;
            list_done <= 1'b0;
        end else begin
            move_valid <= take;
            list_done <= scan_end;
            if (take && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (!take && credit_return && !credits_full) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            move_out <= offer;
        end
    end

endmodule

`default_nettype wire

// ==== source/piece_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module piece_scanner (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  movegen_pkg::decoded_t decoded,
    input  logic                  start,
    input  logic                  take,
    output movegen_pkg::move_t    offer,
    output logic                  offer_valid,
    output logic                  scan_end
);
    import movegen_pkg::*;

    function automatic logic [SQ_W-1:0] trailing_zeros(input bitboard_t bits);
        logic [SQ_W-1:0] idx;

        idx = '0;
        for (int i = BOARD_SQUARES - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = SQ_W'(i);
            end
        end
        return idx;
    endfunction

    scan_state_t state;
    scan_state_t next_class;
    logic        setup;
    logic        in_class;
    logic        last_dst;
    bitboard_t   src_set;
    bitboard_t   dst_set;
    bitboard_t   next_class_set;
    bitboard_t   attacks;
    bitboard_t   king_mask;
    bitboard_t   knight_mask;
    bitboard_t   diag_mask;
    bitboard_t   ortho_mask;
    square_t     cur_sq;

    // current piece is always the lowest remaining source
    assign cur_sq = square_t'(trailing_zeros(src_set));

    leaper_attacks u_leaper (
        .sq          (cur_sq),
        .king_mask   (king_mask),
        .knight_mask (knight_mask)
    );

    slider_attacks u_slider (
        .sq         (cur_sq),
        .occupied   (decoded.occupied),
        .ortho_mask (ortho_mask),
        .diag_mask  (diag_mask)
    );

    always_comb begin
        attacks = '0;
        next_class = SCAN_DONE;
        next_class_set = '0;
        case (state)
            SCAN_KING: begin
                attacks = king_mask;
                next_class = SCAN_KNIGHT;
                next_class_set = decoded.knight_set;
            end
            SCAN_KNIGHT: begin
                attacks = knight_mask;
                next_class = SCAN_DIAG;
                next_class_set = decoded.diag_set;
            end
            SCAN_DIAG: begin
                attacks = diag_mask;
                next_class = SCAN_ORTHO;
                next_class_set = decoded.ortho_set;
            end
            SCAN_ORTHO: begin
                attacks = ortho_mask;
            end
            default: begin
                attacks = '0;
            end
        endcase
    end

    assign in_class = state inside {SCAN_KING, SCAN_KNIGHT, SCAN_DIAG, SCAN_ORTHO};
    assign offer_valid = in_class && !setup && (dst_set != '0);
    assign offer.src = cur_sq;
    assign offer.dst = square_t'(trailing_zeros(dst_set));
    assign last_dst = (dst_set & (dst_set - 1'b1)) == '0;
    assign scan_end = state == SCAN_DONE;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= SCAN_IDLE;
            setup <= 1'b0;
            src_set <= '0;
            dst_set <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (start) begin
                        // the king is a class with a single piece
                        state <= SCAN_KING;
                        src_set <= bitboard_t'(1) << decoded.king_sq;
                        setup <= 1'b1;
                    end
                end
                SCAN_DONE: begin
                    state <= SCAN_IDLE;
                end
                default: begin
                    if (setup) begin
                        if (src_set == '0) begin
                            state <= next_class;
                            src_set <= next_class_set;
                        end else begin
                            dst_set <= attacks & decoded.dest_mask;
                            setup <= 1'b0;
                        end
                    end else if (dst_set == '0) begin
                        // piece without any destination
                        src_set <= src_set & (src_set - 1'b1);
                        setup <= 1'b1;
                    end else if (take) begin
                        dst_set <= dst_set & (dst_set - 1'b1);
                        if (last_dst) begin
                            src_set <= src_set & (src_set - 1'b1);
                            setup <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/slider_attacks.sv ====
`timescale 1ns/1ps
`default_nettype none

module slider_attacks (
    input  movegen_pkg::square_t   sq,
    input  movegen_pkg::bitboard_t occupied,
    output movegen_pkg::bitboard_t ortho_mask,
    output movegen_pkg::bitboard_t diag_mask
);
    import movegen_pkg::*;

    function automatic logic [7:0] rev8(input logic [7:0] v);
        logic [7:0] r;

        for (int i = 0; i < 8; i++) begin
            r[i] = v[7 - i];
        end
        return r;
    endfunction

    // reverses rank order, one line square per rank keeps its place
    function automatic bitboard_t swap_ranks(input bitboard_t v);
        bitboard_t r;

        for (int i = 0; i < 8; i++) begin
            r[i*8 +: 8] = v[(7 - i)*8 +: 8];
        end
        return r;
    endfunction

    logic [SQ_W-1:0] src;
    bitboard_t       src_bit;
    bitboard_t       others;

    assign src = sq;
    assign src_bit = bitboard_t'(1) << src;
    // the slider itself must not count as a blocker
    assign others = occupied & ~src_bit;

    always_comb begin
        logic [7:0] rank_occ;
        logic [7:0] file_occ;
        logic [7:0] fil_bit;
        logic [7:0] rnk_bit;
        logic [7:0] rank_atk;
        logic [7:0] file_atk;

        rank_occ = others[{sq.rnk, 3'b000} +: 8];
        for (int i = 0; i < 8; i++) begin
            file_occ[i] = others[i*8 + sq.fil];
        end
        fil_bit = 8'd1 << sq.fil;
        rnk_bit = 8'd1 << sq.rnk;

        // forward ray from the subtract, backward ray from the reversed subtract
        rank_atk = (rank_occ - fil_bit) ^ rev8(rev8(rank_occ) - rev8(fil_bit));
        file_atk = (file_occ - rnk_bit) ^ rev8(rev8(file_occ) - rev8(rnk_bit));

        ortho_mask = '0;
        for (int i = 0; i < 8; i++) begin
            ortho_mask[{sq.rnk, 3'b000} + i] = rank_atk[i];
        end
        for (int i = 0; i < 8; i++) begin
            if (file_atk[i]) begin
                ortho_mask[i*8 + sq.fil] = 1'b1;
            end
        end
    end

    always_comb begin
        logic [4:0]   diag_idx;
        logic [4:0]   anti_idx;
        logic [119:0] diag_wide;
        logic [119:0] anti_wide;
        bitboard_t    diag_line;
        bitboard_t    anti_line;
        bitboard_t    diag_occ;
        bitboard_t    anti_occ;
        bitboard_t    diag_atk;
        bitboard_t    anti_atk;

        diag_idx = {2'b0, sq.rnk} + {2'b0, ~sq.fil};
        anti_idx = {2'b0, sq.rnk} + {2'b0, sq.fil};

        // slide the main lines by whole ranks onto the square
        diag_wide = {56'b0, DIAG_LINE} << {diag_idx, 3'b000};
        anti_wide = {56'b0, ANTI_LINE} << {anti_idx, 3'b000};
        diag_line = diag_wide[119:56];
        anti_line = anti_wide[119:56];

        diag_occ = others & diag_line;
        anti_occ = others & anti_line;

        diag_atk = (diag_occ - src_bit)
                 ^ swap_ranks(swap_ranks(diag_occ) - swap_ranks(src_bit));
        anti_atk = (anti_occ - src_bit)
                 ^ swap_ranks(swap_ranks(anti_occ) - swap_ranks(src_bit));

        // borrows run through squares off the line
        diag_mask = (diag_atk & diag_line) | (anti_atk & anti_line);
    end

endmodule

`default_nettype wire

// ==== source/leaper_attacks.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaper_attacks (
    input  movegen_pkg::square_t   sq,
    output movegen_pkg::bitboard_t king_mask,
    output movegen_pkg::bitboard_t knight_mask
);
    import movegen_pkg::*;

    logic [6:0]   king_shift;
    logic [7:0]   knight_shift;
    logic [99:0]  king_frame;
    logic [143:0] knight_frame;

    // one frame row per rank plus padding columns on both sides
    assign king_shift = {4'b0, sq.rnk} * 7'd10 + {4'b0, sq.fil};
    assign knight_shift = {5'b0, sq.rnk} * 8'd12 + {5'b0, sq.fil};

    assign king_frame = KING_FRAME << king_shift;
    assign knight_frame = KNIGHT_FRAME << knight_shift;

    // pull the 8x8 window back out, moves off the edge land in padding
    for (genvar r = 0; r < 8; r++) begin : g_rank
        assign king_mask[r*8 +: 8] = king_frame[r*10 + 11 +: 8];
        assign knight_mask[r*8 +: 8] = knight_frame[r*12 + 26 +: 8];
    end

endmodule

`default_nettype wire

// ==== source/board_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_decode (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  movegen_pkg::board_t   board_in,
    input  logic                  board_valid,
    input  logic                  captures_only,
    input  logic                  list_done,
    output logic                  board_ready,
    output movegen_pkg::decoded_t decoded,
    output logic                  start
);
    import movegen_pkg::*;

    logic     busy;
    logic     accept;
    decoded_t decoded_next;

    assign board_ready = !busy;
    assign accept = board_valid && board_ready;

    always_comb begin
        bitboard_t occ;
        bitboard_t own;
        bitboard_t allies;

        occ = '0;
        for (int k = 0; k <= int'(QUEEN); k++) begin
            occ = occ | board_in.pieces[k];
        end
        occ = occ | (bitboard_t'(1) << board_in.kings[0]);
        occ = occ | (bitboard_t'(1) << board_in.kings[1]);

        own = board_in.black_to_move ? ~board_in.white_men : board_in.white_men;
        allies = occ & own;

        decoded_next.occupied = occ;
        // captures only means enemy squares and nothing else
        decoded_next.dest_mask = captures_only ? (occ & ~own) : ~allies;
        decoded_next.king_sq = board_in.black_to_move ? board_in.kings[1] : board_in.kings[0];
        decoded_next.knight_set = board_in.pieces[KNIGHT] & allies;
        decoded_next.diag_set = (board_in.pieces[BISHOP] | board_in.pieces[QUEEN]) & allies;
        decoded_next.ortho_set = (board_in.pieces[ROOK] | board_in.pieces[QUEEN]) & allies;
    end

    // busy from accept until the scanner has finished
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (list_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            decoded <= decoded_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/movegen_pkg.sv ====
`default_nettype none

package movegen_pkg;

    localparam int BOARD_SQUARES = 64;
    localparam int SQ_W = 6;
    localparam int MOVE_CREDITS = 4;
    localparam int CREDIT_W = $clog2(MOVE_CREDITS + 1);

    // king pattern on a 10-wide frame, centred on bit 11
    localparam logic [99:0] KING_FRAME = 100'h701407;
    // knight pattern on a 12-wide frame, centred on bit 26
    localparam logic [143:0] KNIGHT_FRAME = 144'ha01100001100a;

    // a1-h8 diagonal and a8-h1 anti-diagonal
    localparam logic [63:0] DIAG_LINE = 64'h8040201008040201;
    localparam logic [63:0] ANTI_LINE = 64'h0102040810204080;

    // square index is rnk * 8 + fil, a1 is bit 0
    typedef logic [BOARD_SQUARES-1:0] bitboard_t;

    typedef struct packed {
        logic [2:0] rnk;
        logic [2:0] fil;
    } square_t;

    typedef enum logic [2:0] {
        PAWN,
        KNIGHT,
        BISHOP,
        ROOK,
        QUEEN
    } piece_kind_t;

    typedef struct packed {
        bitboard_t [4:0] pieces;
        // white king square is expected here as well
        bitboard_t       white_men;
        // white king in slot 0
        square_t [0:1]   kings;
        logic            black_to_move;
    } board_t;

    typedef struct packed {
        square_t src;
        square_t dst;
    } move_t;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_KING,
        SCAN_KNIGHT,
        SCAN_DIAG,
        SCAN_ORTHO,
        SCAN_DONE
    } scan_state_t;

    typedef struct packed {
        bitboard_t occupied;
        bitboard_t dest_mask;
        square_t   king_sq;
        bitboard_t knight_set;
        bitboard_t diag_set;
        bitboard_t ortho_set;
    } decoded_t;

endpackage

`default_nettype wire
